// ==== logic/mgt_tx_pkg.sv ====
package mgt_tx_pkg;

    // Comma character K28.5
    localparam logic [7:0]  k28_5      = 8'hBC;
    localparam logic [15:0] comma_word = {k28_5, k28_5};  // Sent with both K flags set

    // Payload words that follow the comma, used in index order
    localparam int payload_count = 3;
    localparam logic [payload_count-1:0][15:0] payload_table = {
        16'h23A7,   // D3.1  D7.5
        16'h4034,   // D0.2  D20.1
        16'h5854    // D24.2 D20.2 at entry 0
    };

    // Running disparity states
    localparam logic rd_neg = 1'b0;
    localparam logic rd_pos = 1'b1;

    // Sub-block view of one byte
    typedef struct packed {
        logic [2:0] hgf;    // Feeds the 3b/4b code
        logic [4:0] edcba;  // Feeds the 5b/6b code
    } byte_fields_t;

    // One byte read raw or as its two 8b/10b fields
    typedef union packed {
        logic [7:0]   raw;
        byte_fields_t f;
    } byte_u;

endpackage

// ==== logic/enc_8b10b.sv ====
`timescale 1ns/1ps

module enc_8b10b (
    input  mgt_tx_pkg::byte_u data_in,
    input  logic              is_k,     // Control character request
    input  logic              rd_in,    // Disparity before this byte
    output logic [9:0]        code,     // Bit a at 0, bit j at 9
    output logic              rd_out    // Disparity after this byte
);

    logic [4:0] x;          // EDCBA
    logic [2:0] y;          // HGF
    logic [5:0] six_neg;    // 5b/6b code for RD-, a at bit 5
    logic [5:0] abcdei;
    logic [3:0] four_neg;   // 3b/4b code for RD-, f at bit 3
    logic [3:0] fghj;
    logic       rd_mid;     // Disparity between the sub-blocks
    logic       use_a7;
    logic [9:0] sym_w;      // Code in transmit order, a at bit 9

    assign x = data_in.f.edcba;
    assign y = data_in.f.hgf;

    // 5b/6b lookup
    always_comb
    begin
        case (x)
            5'd0:    six_neg = 6'b100111;
            5'd1:    six_neg = 6'b011101;
            5'd2:    six_neg = 6'b101101;
            5'd3:    six_neg = 6'b110001;
            5'd4:    six_neg = 6'b110101;
            5'd5:    six_neg = 6'b101001;
            5'd6:    six_neg = 6'b011001;
            5'd7:    six_neg = 6'b111000;  // Balanced but flips with disparity
            5'd8:    six_neg = 6'b111001;
            5'd9:    six_neg = 6'b100101;
            5'd10:   six_neg = 6'b010101;
            5'd11:   six_neg = 6'b110100;
            5'd12:   six_neg = 6'b001101;
            5'd13:   six_neg = 6'b101100;
            5'd14:   six_neg = 6'b011100;
            5'd15:   six_neg = 6'b010111;
            5'd16:   six_neg = 6'b011011;
            5'd17:   six_neg = 6'b100011;
            5'd18:   six_neg = 6'b010011;
            5'd19:   six_neg = 6'b110010;
            5'd20:   six_neg = 6'b001011;
            5'd21:   six_neg = 6'b101010;
            5'd22:   six_neg = 6'b011010;
            5'd23:   six_neg = 6'b111010;  // Also K23
            5'd24:   six_neg = 6'b110011;
            5'd25:   six_neg = 6'b100110;
            5'd26:   six_neg = 6'b010110;
            5'd27:   six_neg = 6'b110110;  // Also K27
            5'd28:   six_neg = 6'b001110;
            5'd29:   six_neg = 6'b101110;  // Also K29
            5'd30:   six_neg = 6'b011110;  // Also K30
            default: six_neg = 6'b101011;  // D.31
        endcase
        if (is_k && x == 5'd28)
            six_neg = 6'b001111;           // K28 has its own 6b form

        // Unbalanced codes and D.07 invert at RD+
        if (rd_in == mgt_tx_pkg::rd_pos && ($countones(six_neg) != 3 || x == 5'd7))
            abcdei = ~six_neg;
        else
            abcdei = six_neg;

        if ($countones(abcdei) > 3)
            rd_mid = mgt_tx_pkg::rd_pos;
        else if ($countones(abcdei) < 3)
            rd_mid = mgt_tx_pkg::rd_neg;
        else
            rd_mid = rd_in;
    end

    // Alternate x.7 avoids a run of five in the e i f g h j boundary
    assign use_a7 = (y == 3'd7) &&
                    (is_k ||
                     (rd_mid == mgt_tx_pkg::rd_neg && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
                     (rd_mid == mgt_tx_pkg::rd_pos && (x == 5'd11 || x == 5'd13 || x == 5'd14)));

    // 3b/4b lookup, K forms differ for y of 1, 2, 5 and 6
    always_comb
    begin
        case (y)
            3'd0:    four_neg = 4'b1011;
            3'd1:    four_neg = is_k ? 4'b0110 : 4'b1001;
            3'd2:    four_neg = is_k ? 4'b1010 : 4'b0101;
            3'd3:    four_neg = 4'b1100;
            3'd4:    four_neg = 4'b1101;
            3'd5:    four_neg = is_k ? 4'b0101 : 4'b1010;
            3'd6:    four_neg = is_k ? 4'b1001 : 4'b0110;
            default: four_neg = use_a7 ? 4'b0111 : 4'b1110;  // A7 or P7
        endcase

        // x.3 and every K form invert at RD+ even when balanced
        if (rd_mid == mgt_tx_pkg::rd_pos &&
            ($countones(four_neg) != 2 || y == 3'd3 || is_k))
            fghj = ~four_neg;
        else
            fghj = four_neg;

        if ($countones(fghj) > 2)
            rd_out = mgt_tx_pkg::rd_pos;
        else if ($countones(fghj) < 2)
            rd_out = mgt_tx_pkg::rd_neg;
        else
            rd_out = rd_mid;
    end

    // Bit a goes out first, so it lands at code[0]
    assign sym_w = {abcdei, fghj};

    always_comb
    begin
        for (int i = 0; i < 10; i++)
            code[i] = sym_w[9 - i];
    end

    // Only K28.y and K23/K27/K29/K30.7 exist
    always_comb
    begin
        if (is_k)
            assert final (x == 5'd28 ||
                          (y == 3'd7 && (x == 5'd23 || x == 5'd27 || x == 5'd29 || x == 5'd30)))
                else $error("enc_8b10b: no K code for byte %h", data_in.raw);
    end

endmodule

// ==== logic/frame_gen.sv ====
`timescale 1ns/1ps

module frame_gen #(
    parameter int frame_words = 8     // Words per frame with the comma, at least 2
) (
    input  logic        tx_clk,
    input  logic        arst_n,
    input  logic        ready,        // Transmit reset done
    output logic [15:0] tx_data,
    output logic [1:0]  tx_is_k       // Bit 0 low byte, bit 1 high byte
);

    localparam int idx_w = $clog2(frame_words);
    localparam int ptr_w = $clog2(mgt_tx_pkg::payload_count);

    localparam logic [idx_w-1:0] idx_last = idx_w'(frame_words - 1);
    localparam logic [ptr_w-1:0] ptr_last = ptr_w'(mgt_tx_pkg::payload_count - 1);

    logic [idx_w-1:0] idx;      // Position in frame, 0 is the comma
    logic [ptr_w-1:0] pay_ptr;  // Payload table entry for the next data word

    always_ff @(posedge tx_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            idx     <= '0;
            pay_ptr <= '0;
            tx_data <= '0;
            tx_is_k <= '0;
        end
        else if (!ready)
        begin
            // Idle zeros, frame restarts when ready returns
            idx     <= '0;
            pay_ptr <= '0;
            tx_data <= '0;
            tx_is_k <= '0;
        end
        else
        begin
            if (idx == '0)
            begin
                tx_data <= mgt_tx_pkg::comma_word;
                tx_is_k <= 2'b11;                                  // K flags from position
            end
            else
            begin
                tx_data <= mgt_tx_pkg::payload_table[pay_ptr];
                tx_is_k <= 2'b00;
            end

            if (idx == idx_last)
            begin
                idx     <= '0;                                     // Wrap to next comma
                pay_ptr <= '0;
            end
            else
            begin
                idx <= idx + 1'b1;
                if (idx != '0)
                    pay_ptr <= (pay_ptr == ptr_last) ? '0 : pay_ptr + 1'b1;  // Mod 3 walk
            end
        end
    end

    // K flags come as a pair and only on the comma word
    assert property (@(posedge tx_clk) disable iff (!arst_n)
        (tx_is_k == 2'b00) ||
        (tx_is_k == 2'b11 && tx_data == mgt_tx_pkg::comma_word))
        else $error("frame_gen: bad K flags %b with data %h", tx_is_k, tx_data);

endmodule

// ==== logic/lane_encoder.sv ====
`timescale 1ns/1ps

module lane_encoder (
    input  logic        tx_clk,
    input  logic        arst_n,
    input  logic [15:0] tx_data,
    input  logic [1:0]  tx_is_k,
    output logic [19:0] tx_symbol    // Low byte code in 9:0, sent first
);

    logic       rd_q;       // Running disparity between cycles
    logic       rd_mid;     // After the low byte
    logic       rd_next;    // After the high byte
    logic [9:0] code_lo;
    logic [9:0] code_hi;

    // Low byte first, from the held disparity
    enc_8b10b enc_lo_i (
        .data_in (mgt_tx_pkg::byte_u'(tx_data[7:0])),
        .is_k    (tx_is_k[0]),
        .rd_in   (rd_q),
        .code    (code_lo),
        .rd_out  (rd_mid)
    );

    // High byte continues from the low byte
    enc_8b10b enc_hi_i (
        .data_in (mgt_tx_pkg::byte_u'(tx_data[15:8])),
        .is_k    (tx_is_k[1]),
        .rd_in   (rd_mid),
        .code    (code_hi),
        .rd_out  (rd_next)
    );

    always_ff @(posedge tx_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            tx_symbol <= '0;
            rd_q      <= mgt_tx_pkg::rd_neg;   // Link starts at RD-
        end
        else
        begin
            tx_symbol <= {code_hi, code_lo};
            rd_q      <= rd_next;
        end
    end

    // Every code word is 4, 5 or 6 ones once the first symbol is loaded
    assert property (@(posedge tx_clk) disable iff (!arst_n)
        $past(arst_n) |->
            ($countones(tx_symbol[9:0]) inside {4, 5, 6}) &&
            ($countones(tx_symbol[19:10]) inside {4, 5, 6}))
        else $error("lane_encoder: unbalanced code pair %h", tx_symbol);

endmodule

// ==== logic/mgt_tx_top.sv ====
`timescale 1ns/1ps

module mgt_tx_top #(
    parameter int frame_words = 8    // Words per frame with the comma
) (
    input  logic        tx_clk,
    input  logic        arst_n,
    input  logic        ready,       // Transceiver transmit reset done
    output logic [15:0] tx_data,     // Parallel word to the transceiver
    output logic [1:0]  tx_is_k,     // Per-byte K flags
    output logic [19:0] tx_symbol    // Coded symbol pair
);

    // Frame words, one per clock
    frame_gen #(
        .frame_words (frame_words)
    ) frame_gen_i (
        .tx_clk  (tx_clk),
        .arst_n  (arst_n),
        .ready   (ready),
        .tx_data (tx_data),
        .tx_is_k (tx_is_k)
    );

    // One cycle behind the generator
    lane_encoder lane_encoder_i (
        .tx_clk    (tx_clk),
        .arst_n    (arst_n),
        .tx_data   (tx_data),
        .tx_is_k   (tx_is_k),
        .tx_symbol (tx_symbol)
    );

endmodule

// ==== include/tb_enc_model.svh ====
`ifndef TB_ENC_MODEL_SVH
`define TB_ENC_MODEL_SVH

// 5b/6b codes at RD-, written abcdei with a as the MSB
localparam logic [5:0] model_6b [32] = '{
    6'b100111, 6'b011101, 6'b101101, 6'b110001, 6'b110101, 6'b101001, 6'b011001, 6'b111000,
    6'b111001, 6'b100101, 6'b010101, 6'b110100, 6'b001101, 6'b101100, 6'b011100, 6'b010111,
    6'b011011, 6'b100011, 6'b010011, 6'b110010, 6'b001011, 6'b101010, 6'b011010, 6'b111010,
    6'b110011, 6'b100110, 6'b010110, 6'b110110, 6'b001110, 6'b101110, 6'b011110, 6'b101011
};

// 3b/4b codes at RD-, written fghj
localparam logic [3:0] model_4b_d [8] = '{
    4'b1011, 4'b1001, 4'b0101, 4'b1100, 4'b1101, 4'b1010, 4'b0110, 4'b1110
};
localparam logic [3:0] model_4b_k [8] = '{
    4'b1011, 4'b0110, 4'b1010, 4'b1100, 4'b1101, 4'b0101, 4'b1001, 4'b0111
};

// Model state the testbench steps each cycle
int unsigned model_idx;    // Predicted frame position
logic        model_rd;     // Predicted running disparity

// Returns {rd_out, code}, code bit a at position 0
function automatic logic [10:0] encode_byte(input logic [7:0] b, input logic k,
                                            input logic rd);
    logic [4:0] x;
    logic [2:0] y;
    logic [5:0] six;
    logic [3:0] four;
    logic       rd6;
    logic       rd4;
    logic [9:0] w;
    logic [9:0] code;
    x = b[4:0];
    y = b[7:5];
    six = (k && x == 5'd28) ? 6'b001111 : model_6b[x];
    if (rd == mgt_tx_pkg::rd_pos && ($countones(six) != 3 || x == 5'd7))
        six = ~six;
    rd6 = ($countones(six) == 3) ? rd :
          ($countones(six) > 3) ? mgt_tx_pkg::rd_pos : mgt_tx_pkg::rd_neg;
    four = k ? model_4b_k[y] : model_4b_d[y];
    if (!k && y == 3'd7 &&
        ((rd6 == mgt_tx_pkg::rd_neg && (x == 5'd17 || x == 5'd18 || x == 5'd20)) ||
         (rd6 == mgt_tx_pkg::rd_pos && (x == 5'd11 || x == 5'd13 || x == 5'd14))))
        four = 4'b0111;                                // Alternate D.x.7
    if (rd6 == mgt_tx_pkg::rd_pos && ($countones(four) != 2 || y == 3'd3 || k))
        four = ~four;
    rd4 = ($countones(four) == 2) ? rd6 :
          ($countones(four) > 2) ? mgt_tx_pkg::rd_pos : mgt_tx_pkg::rd_neg;
    w = {six, four};
    for (int i = 0; i < 10; i++)
        code[i] = w[9 - i];
    return {rd4, code};
endfunction

// Returns {rd_out, symbol pair}, low byte first
function automatic logic [20:0] encode_word(input logic [15:0] data, input logic [1:0] k,
                                            input logic rd);
    logic [10:0] lo;
    logic [10:0] hi;
    lo = encode_byte(data[7:0], k[0], rd);
    hi = encode_byte(data[15:8], k[1], lo[10]);
    return {hi[10], hi[9:0], lo[9:0]};
endfunction

// Expected {K flags, data} at a frame position
function automatic logic [17:0] frame_word_at(input int unsigned idx);
    if (idx == 0)
        return {2'b11, mgt_tx_pkg::comma_word};
    return {2'b00, mgt_tx_pkg::payload_table[(idx - 1) % mgt_tx_pkg::payload_count]};
endfunction

// Frame position after one word with ready high
function automatic int unsigned next_frame_idx(input int unsigned idx, input int unsigned words);
    return (idx + 1 == words) ? 0 : idx + 1;
endfunction

// Ones minus zeros of one 10-bit code
function automatic int code_disparity(input logic [9:0] code);
    return 2 * $countones(code) - 10;
endfunction

// K28.5 code expected at a given disparity, abcdei fghj as in the code tables
function automatic logic [9:0] comma_code_for(input logic rd);
    logic [9:0] w;
    logic [9:0] code;
    w = (rd == mgt_tx_pkg::rd_neg) ? 10'b0011111010 : 10'b1100000101;
    for (int i = 0; i < 10; i++)
        code[i] = w[9 - i];
    return code;
endfunction

`endif

// ==== dv/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int frame_words   = 8;    // Passed to the DUT below
    localparam int reset_cycles  = 5;
    localparam int stretch_pairs = 30;   // Low and high ready stretches in the random phase

    logic        tx_clk;
    logic        arst_n;
    logic        ready;
    logic [15:0] tx_data;
    logic [1:0]  tx_is_k;
    logic [19:0] tx_symbol;

    `include "tb_enc_model.svh"

    // Expected outputs after the next rising edge
    logic [15:0] exp_data;
    logic [1:0]  exp_k;
    logic [19:0] exp_sym;
    logic        exp_low;        // Word predicted with ready low
    logic        exp_first;      // First word of a high stretch
    logic        exp_comma;      // Symbol comes from a comma word
    logic [9:0]  exp_comma_lo;
    logic [9:0]  exp_comma_hi;
    int          exp_phase;      // Test that owns this prediction

    int          phase;
    int          disp_sum;       // Ones minus zeros over all codes
    int          commas_seen;
    int          errs [1:5];
    int          tests_failed;
    int          total_errs;
    int unsigned lcg_state;
    int          stretch_len [$];
    int          planned_cycles;
    int          cycle_limit;
    int          cycle_count;

    mgt_tx_top #(
        .frame_words (frame_words)
    ) dut_i (
        .tx_clk    (tx_clk),
        .arst_n    (arst_n),
        .ready     (ready),
        .tx_data   (tx_data),
        .tx_is_k   (tx_is_k),
        .tx_symbol (tx_symbol)
    );

    // 8 ns clock
    initial
    begin
        tx_clk = 1'b0;
        forever #4 tx_clk = ~tx_clk;
    end

    function automatic int unsigned lcg_next(input int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Stretch length from 1 to span
    task automatic draw_len(input int unsigned span, output int len);
        lcg_state = lcg_next(lcg_state);
        len = 1 + int'((lcg_state >> 16) % span);   // Upper bits, the low ones cycle fast
    endtask

    task automatic check_reset_values();
        assert (tx_data === 16'h0) else
        begin
            $display("ERROR tx_data: got %h expected %h", tx_data, 16'h0);
            errs[1]++;
        end
        assert (tx_is_k === 2'b00) else
        begin
            $display("ERROR tx_is_k: got %h expected %h", tx_is_k, 2'b00);
            errs[1]++;
        end
        assert (tx_symbol === 20'h0) else
        begin
            $display("ERROR tx_symbol: got %h expected %h", tx_symbol, 20'h0);
            errs[1]++;
        end
    endtask

    // Compare outputs of the last rising edge with the model
    task automatic check_outputs();
        assert (tx_data === exp_data) else
        begin
            $display("ERROR tx_data: got %h expected %h", tx_data, exp_data);
            errs[exp_phase]++;
        end
        assert (tx_is_k === exp_k) else
        begin
            $display("ERROR tx_is_k: got %h expected %h", tx_is_k, exp_k);
            errs[exp_phase]++;
        end
        if (exp_low)
        begin
            assert (tx_data === 16'h0 && tx_is_k === 2'b00) else
            begin
                $display("Word %h with K flags %h sent while ready was low", tx_data, tx_is_k);
                errs[exp_phase]++;
            end
        end
        if (exp_first)
        begin
            assert (tx_data === mgt_tx_pkg::comma_word && tx_is_k === 2'b11) else
            begin
                $display("High ready stretch began with %h instead of the comma", tx_data);
                errs[exp_phase]++;
            end
        end
        if (exp_phase == 2 && tx_is_k === 2'b11)
            commas_seen++;
        assert (tx_symbol === exp_sym) else
        begin
            $display("ERROR tx_symbol: got %h expected %h", tx_symbol, exp_sym);
            errs[4]++;
        end
        disp_sum += code_disparity(tx_symbol[9:0]);    // Low byte goes out first
        assert (disp_sum >= -2 && disp_sum <= 2) else
        begin
            $display("Disparity sum reached %0d after low code %h", disp_sum,
                     tx_symbol[9:0]);
            errs[5]++;
        end
        disp_sum += code_disparity(tx_symbol[19:10]);
        assert (disp_sum >= -2 && disp_sum <= 2) else
        begin
            $display("Disparity sum reached %0d after high code %h", disp_sum,
                     tx_symbol[19:10]);
            errs[5]++;
        end
        if (exp_comma)
        begin
            assert (tx_symbol[9:0] === exp_comma_lo &&
                    tx_symbol[19:10] === exp_comma_hi) else
            begin
                $display("ERROR tx_symbol: got %h expected comma pair %h", tx_symbol,
                         {exp_comma_hi, exp_comma_lo});
                errs[5]++;
            end
        end
    endtask

    // Step the model one edge and drive ready for it
    task automatic advance(input logic rdy);
        logic [20:0] enc;
        logic [17:0] word;
        exp_comma    = (exp_k == 2'b11);
        exp_comma_lo = comma_code_for(model_rd);
        exp_comma_hi = comma_code_for(!model_rd);      // K28.5 flips the disparity
        enc          = encode_word(exp_data, exp_k, model_rd);
        exp_sym      = enc[19:0];
        model_rd     = enc[20];
        exp_low      = !rdy;
        exp_first    = rdy && !ready;
        exp_phase    = phase;
        if (rdy)
        begin
            word      = frame_word_at(model_idx);
            exp_k     = word[17:16];
            exp_data  = word[15:0];
            model_idx = next_frame_idx(model_idx, frame_words);
        end
        else
        begin
            exp_k     = 2'b00;
            exp_data  = 16'h0;
            model_idx = 0;                              // Frame restarts
        end
        ready = rdy;
    endtask

    task automatic run_cycle(input logic rdy);
        @(negedge tx_clk);
        check_outputs();
        advance(rdy);
    endtask

    task automatic report_test(input int num, input string name);
        if (errs[num] == 0)
            $display("Test %0d %s: passed", num, name);
        else
        begin
            $display("Test %0d %s: failed with %0d errors", num, name, errs[num]);
            tests_failed++;
        end
    endtask

    // Cycle limit guard
    initial
    begin
        cycle_count = 0;
        wait (cycle_limit > 0);
        while (cycle_count <= cycle_limit)
        begin
            @(posedge tx_clk);
            cycle_count++;
        end
        $display("Timeout: run went past %0d cycles", cycle_limit);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial
    begin
        int len;
        arst_n       = 1'b0;
        ready        = 1'b0;
        model_idx    = 0;
        model_rd     = mgt_tx_pkg::rd_neg;
        exp_data     = 16'h0;
        exp_k        = 2'b00;
        exp_sym      = 20'h0;
        exp_low      = 1'b0;
        exp_first    = 1'b0;
        exp_comma    = 1'b0;
        exp_comma_lo = 10'h0;
        exp_comma_hi = 10'h0;
        exp_phase    = 1;
        phase        = 1;
        disp_sum     = 0;
        commas_seen  = 0;
        tests_failed = 0;
        total_errs   = 0;
        cycle_limit  = 0;
        for (int i = 1; i <= 5; i++)
            errs[i] = 0;

        // Random schedule up front, so the limit covers it
        lcg_state      = 32'd12491;
        planned_cycles = reset_cycles + 3 * frame_words + 2;
        for (int i = 0; i < stretch_pairs; i++)
        begin
            draw_len(6, len);
            stretch_len.push_back(len);
            planned_cycles += len;
            draw_len(40, len);
            stretch_len.push_back(len);
            planned_cycles += len;
        end
        cycle_limit = planned_cycles * 3 / 2;

        // Reset held for five cycles
        repeat (reset_cycles)
        begin
            @(negedge tx_clk);
            check_reset_values();
        end
        arst_n = 1'b1;
        check_reset_values();                          // Release alone changes nothing
        advance(1'b0);

        // Three whole frames, first cycle still checks the word after reset
        phase = 2;
        run_cycle(1'b1);
        report_test(1, "reset state");
        repeat (3 * frame_words - 1) run_cycle(1'b1);

        // Random ready, first low cycle also checks the last frame word
        phase = 3;
        run_cycle(1'b0);
        assert (commas_seen == 3) else
        begin
            $display("Saw %0d comma words in three frames", commas_seen);
            errs[2]++;
        end
        report_test(2, "frame content");
        repeat (stretch_len[0] - 1) run_cycle(1'b0);
        repeat (stretch_len[1]) run_cycle(1'b1);
        for (int i = 2; i < stretch_len.size(); i += 2)
        begin
            repeat (stretch_len[i]) run_cycle(1'b0);
            repeat (stretch_len[i + 1]) run_cycle(1'b1);
        end
        run_cycle(1'b0);
        run_cycle(1'b0);                               // Last high word reaches the symbol
        report_test(3, "ready gating");
        report_test(4, "symbol coding");
        report_test(5, "disparity balance");

        for (int i = 1; i <= 5; i++)
            total_errs += errs[i];
        $display("Tests run 5, failed %0d, errors %0d, cycles %0d",
                 tests_failed, total_errs, cycle_count);
        if (tests_failed == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+include
logic/mgt_tx_pkg.sv
logic/enc_8b10b.sv
logic/frame_gen.sv
logic/lane_encoder.sv
logic/mgt_tx_top.sv
dv/tb_top.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --assert --timing -Wno-fatal -j 0
TOP      ?= tb_top
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir
PASS_MSG := TEST RESULT: PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
